//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_console
FILELIST  := rv_console_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard design/*.sv verif/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/console_fifo.sv
// Console transmit FIFO
// Single-clock circular byte buffer, core writes and JTAG reads

`timescale 1ns/1ps
`default_nettype none

module console_fifo (
    input  logic       tck,
    input  logic       reset_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] head,
    output logic       empty,
    output logic       full
);
    import rv_console_pkg::*;

    logic [7:0]                 mem [0:(1 << FIFO_DEPTH_LOG2)-1];
    logic [FIFO_DEPTH_LOG2-1:0] wptr;
    logic [FIFO_DEPTH_LOG2-1:0] rptr;

    // One slot kept free to tell full from empty
    assign empty = (wptr == rptr);
    assign full  = ((wptr + 1'b1) == rptr);
    assign head  = mem[rptr];

    always_ff @(posedge tck) begin
        if (push && !full) begin
            mem[wptr] <= push_data;
        end
    end

    // Pushes into a full buffer are lost
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (push && !full) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    // TAP pops only after capturing a valid byte
    a_no_underflow: assert property (
        @(posedge tck) disable iff (!reset_n)
        pop |-> !empty
    ) else $error("console FIFO popped while empty");

endmodule

`default_nettype wire

//--- design/execute_unit.sv
// Execute stage
// Register file, ADDI writeback and console store request generation

`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                        tck,
    input  logic                        reset_n,
    input  rv_console_pkg::decoded_op_t dec_op,
    output rv_console_pkg::store_req_t  st_req,
    output logic [7:0]                  x10_low
);
    import rv_console_pkg::*;

    logic [XLEN-1:0] regs [0:NUM_REGS-1];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] sum;
    logic            wr_en;

    // ====================
    // Operand read
    // ====================
    // Write lands at the same edge that loads the next op, so no bypass needed
    assign rs1_val = regs[dec_op.rs1];
    assign rs2_val = regs[dec_op.rs2];

    // Shared adder for ADDI result and store address
    assign sum = rs1_val + dec_op.imm;

    // x0 stays hardwired
    assign wr_en = dec_op.valid && dec_op.is_addi && (dec_op.rd != 5'd0);

    // ====================
    // Register file
    // ====================
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[dec_op.rd] <= sum;
        end
    end

    // ====================
    // Store request
    // ====================
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            st_req <= '0;
        end else begin
            st_req.valid <= dec_op.valid && dec_op.is_store;
            st_req.addr  <= sum;
            st_req.data  <= rs2_val;
        end
    end

    // Low byte of a0 for the board LEDs
    assign x10_low = regs[10][7:0];

    a_x0_zero: assert property (
        @(posedge tck) disable iff (!reset_n)
        regs[0] == '0
    ) else $error("register x0 holds a nonzero value");

endmodule

`default_nettype wire

//--- design/instr_decode.sv
// Instruction decoder
// One registered decoded op per instruction strobe

`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic                        tck,
    input  logic                        reset_n,
    input  logic                        instr_valid,
    input  rv_console_pkg::rv_instr_u   instr,
    output rv_console_pkg::decoded_op_t dec_op
);
    import rv_console_pkg::*;

    decoded_op_t op_next;

    // Both formats keep the opcode in the same bits
    always_comb begin
        op_next       = '0;
        op_next.valid = instr_valid;
        case (instr.i_fmt.opcode)
            OPC_ADDI: begin
                op_next.is_addi = 1'b1;
                op_next.rd      = instr.i_fmt.rd;
                op_next.rs1     = instr.i_fmt.rs1;
                op_next.imm     = {{(XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            OPC_STORE: begin
                op_next.is_store = 1'b1;
                op_next.rs1      = instr.s_fmt.rs1;
                op_next.rs2      = instr.s_fmt.rs2;
                op_next.imm      = {{(XLEN-12){instr.s_fmt.imm_hi[6]}},
                                    instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            end
            default: begin
                // Anything else passes through as a no-op
            end
        endcase
    end

    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            dec_op <= '0;
        end else begin
            dec_op <= op_next;
        end
    end

    // Execute relies on at most one action per op
    a_one_kind: assert property (
        @(posedge tck) disable iff (!reset_n)
        !(dec_op.is_addi && dec_op.is_store)
    ) else $error("decoded op flagged as both ADDI and store");

endmodule

`default_nettype wire

//--- design/jtag_tap.sv
// JTAG TAP controller
// 16-state FSM, IR with update stage, bypass bit, USER1 console register

`timescale 1ns/1ps
`default_nettype none

module jtag_tap (
    input  logic       tck,
    input  logic       reset_n,
    input  logic       tms,
    input  logic       tdi,
    output logic       tdo,
    input  logic [7:0] fifo_head,
    input  logic       fifo_empty,
    output logic       fifo_pop
);
    import rv_console_pkg::*;

    tap_state_e        state;
    tap_state_e        state_next;
    logic [IR_LEN-1:0] ir_shift;
    logic [IR_LEN-1:0] ir_active;
    logic [DR_LEN-1:0] dr;
    logic              bypass_bit;
    logic              cap_valid;
    logic              is_user1;

    // ====================
    // TAP state machine
    // ====================
    always_comb begin
        case (state)
            TLR:     state_next = tms ? TLR  : RTI;
            RTI:     state_next = tms ? SDR  : RTI;
            SDR:     state_next = tms ? SIR  : CDR;
            CDR:     state_next = tms ? E1DR : SDRS;
            SDRS:    state_next = tms ? E1DR : SDRS;
            E1DR:    state_next = tms ? UDR  : PDR;
            PDR:     state_next = tms ? E2DR : PDR;
            E2DR:    state_next = tms ? UDR  : SDRS;
            UDR:     state_next = tms ? SDR  : RTI;
            SIR:     state_next = tms ? TLR  : CIR;
            CIR:     state_next = tms ? E1IR : SIRS;
            SIRS:    state_next = tms ? E1IR : SIRS;
            E1IR:    state_next = tms ? UIR  : PIR;
            PIR:     state_next = tms ? E2IR : PIR;
            E2IR:    state_next = tms ? UIR  : SIRS;
            UIR:     state_next = tms ? SDR  : RTI;
            default: state_next = TLR;
        endcase
    end

    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            state <= TLR;
        end else begin
            state <= state_next;
        end
    end

    // ====================
    // Instruction register
    // ====================
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            ir_shift  <= '0;
            ir_active <= IR_BYPASS;
        end else begin
            // Capture pattern ends in 01 as the standard requires
            if (state == CIR) begin
                ir_shift <= {{(IR_LEN-2){1'b0}}, 2'b01};
            end else if (state == SIRS) begin
                ir_shift <= {tdi, ir_shift[IR_LEN-1:1]};
            end
            if (state == TLR) begin
                ir_active <= IR_BYPASS;
            end else if (state == UIR) begin
                ir_active <= ir_shift;
            end
        end
    end

    assign is_user1 = (ir_active == IR_USER1);

    // ====================
    // Data registers
    // ====================
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            dr         <= '0;
            bypass_bit <= 1'b0;
            cap_valid  <= 1'b0;
        end else begin
            if (state == CDR) begin
                bypass_bit <= 1'b0;
                cap_valid  <= is_user1 && !fifo_empty;
                if (is_user1) begin
                    dr <= fifo_empty ? '0 : {1'b1, fifo_head};
                end
            end else if (state == SDRS) begin
                bypass_bit <= tdi;
                if (is_user1) begin
                    dr <= {tdi, dr[DR_LEN-1:1]};
                end
            end
        end
    end

    // Byte is consumed only once the host completes the scan
    assign fifo_pop = (state == UDR) && cap_valid;

    always_comb begin
        if (state == SIRS) begin
            tdo = ir_shift[0];
        end else if (state == SDRS && is_user1) begin
            tdo = dr[0];
        end else begin
            tdo = bypass_bit;
        end
    end

    // All sixteen codes are states, so only X/Z is illegal
    a_state_known: assert property (
        @(posedge tck) disable iff (!reset_n)
        !$isunknown(state)
    ) else $error("TAP state has an unknown encoding");

endmodule

`default_nettype wire

//--- design/rv_console_pkg.sv
// Shared constants and types for the debug console core
// Opcodes, instruction formats, pipeline structs, TAP states, IR codes

`default_nettype none

package rv_console_pkg;

    // ====================
    // Core
    // ====================
    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;

    localparam logic [6:0] OPC_ADDI  = 7'b0010011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // Same 32-bit word seen as I-type or S-type
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s_fmt;
    } rv_instr_u;

    typedef struct packed {
        logic            valid;
        logic            is_addi;
        logic            is_store;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;
    } decoded_op_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } store_req_t;

    // ====================
    // Console FIFO and JTAG
    // ====================
    localparam int FIFO_DEPTH_LOG2 = 4;

    localparam int             IR_LEN    = 10;
    localparam logic [IR_LEN-1:0] IR_USER1  = 10'h00C;
    localparam logic [IR_LEN-1:0] IR_BYPASS = '1;

    // Valid flag in the MSB, console byte below it
    localparam int DR_LEN = 9;

    typedef enum logic [3:0] {
        TLR, RTI,
        SDR, CDR, SDRS, E1DR, PDR, E2DR, UDR,
        SIR, CIR, SIRS, E1IR, PIR, E2IR, UIR
    } tap_state_e;

endpackage

`default_nettype wire

//--- design/rv_console_top.sv
// Debug console top level
// Decode, execute, console FIFO and JTAG TAP

`timescale 1ns/1ps
`default_nettype none

module rv_console_top (
    input  logic        tck,
    input  logic        reset_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic        tms,
    input  logic        tdi,
    output logic        tdo,
    output logic [7:0]  x10_low
);
    import rv_console_pkg::*;

    decoded_op_t dec_op;
    store_req_t  st_req;
    logic        fifo_push;
    logic        fifo_pop;
    logic [7:0]  fifo_head;
    logic        fifo_empty;

    // Bit 31 of the address selects the console
    assign fifo_push = st_req.valid && st_req.addr[31];

    instr_decode u_decode (
        .tck         (tck),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_op      (dec_op)
    );

    execute_unit u_execute (
        .tck     (tck),
        .reset_n (reset_n),
        .dec_op  (dec_op),
        .st_req  (st_req),
        .x10_low (x10_low)
    );

    console_fifo u_fifo (
        .tck       (tck),
        .reset_n   (reset_n),
        .push      (fifo_push),
        .push_data (st_req.data[7:0]),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .full      ()
    );

    jtag_tap u_tap (
        .tck        (tck),
        .reset_n    (reset_n),
        .tms        (tms),
        .tdi        (tdi),
        .tdo        (tdo),
        .fifo_head  (fifo_head),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop)
    );

endmodule

`default_nettype wire

//--- rv_console_top.f
design/rv_console_pkg.sv
design/instr_decode.sv
design/execute_unit.sv
design/console_fifo.sv
design/jtag_tap.sv
design/rv_console_top.sv
verif/tb_rv_console.sv

//--- verif/tb_rv_console.sv
// Testbench for the debug console
// Random ADDI and store programs, reference model, JTAG host tasks, checks

`timescale 1ns/1ps
`default_nettype none

module tb_rv_console;

    localparam int N_INSTR    = 200;
    localparam int N_SCANS    = 30;
    localparam int CLK_NS     = 4;
    localparam int TIMEOUT_NS = (N_INSTR + N_SCANS * 30) * CLK_NS * 2;

    typedef struct packed {
        logic       valid;
        logic [7:0] x10;
    } x10_check_t;

    logic        tck;
    logic        reset_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        tms;
    logic        tdi;
    logic        tdo;
    logic [7:0]  x10_low;

    logic [63:0] model_regs [0:31];
    logic [7:0]  exp_bytes [$];
    x10_check_t  cur_chk;
    x10_check_t  d1_chk;
    x10_check_t  d2_chk;
    integer      seed;
    int          error_count;
    int          check_count;

    rv_console_top rv_console_top_i (
        .tck         (tck),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .tms         (tms),
        .tdi         (tdi),
        .tdo         (tdo),
        .x10_low     (x10_low)
    );

    always #2 tck = ~tck;

    // ====================
    // Reference model
    // ====================
    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_store(input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    // Runs one instruction on the model, returns x10 afterwards
    function automatic logic [63:0] ref_exec(input logic [31:0] ins, output logic has_byte,
                                             output logic [7:0] byte_val);
        logic [63:0] imm_i;
        logic [63:0] imm_s;
        logic [63:0] addr;
        has_byte = 1'b0;
        byte_val = 8'h00;
        imm_i    = {{52{ins[31]}}, ins[31:20]};
        imm_s    = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        if (ins[6:0] == 7'b0010011) begin
            if (ins[11:7] != 5'd0) begin
                model_regs[ins[11:7]] = model_regs[ins[19:15]] + imm_i;
            end
        end else if (ins[6:0] == 7'b0100011) begin
            addr = model_regs[ins[19:15]] + imm_s;
            // Console window is any address with bit 31 set
            if (addr[31]) begin
                has_byte = 1'b1;
                byte_val = model_regs[ins[24:20]][7:0];
            end
        end
        return model_regs[10];
    endfunction

    // ====================
    // Core stimulus
    // ====================
    task automatic issue(input logic [31:0] ins);
        logic        has_byte;
        logic [7:0]  byte_val;
        logic [63:0] x10;
        x10 = ref_exec(ins, has_byte, byte_val);
        // FIFO keeps one slot free, so 15 bytes at most
        if (has_byte && exp_bytes.size() < 15) begin
            exp_bytes.push_back(byte_val);
        end
        instr_valid   = 1'b1;
        instr         = ins;
        cur_chk.valid = 1'b1;
        cur_chk.x10   = x10[7:0];
        @(posedge tck);
        #0.5;
    endtask

    task automatic idle(input int cycles);
        instr_valid = 1'b0;
        instr       = '0;
        cur_chk     = '0;
        repeat (cycles) begin
            @(posedge tck);
            #0.5;
        end
    endtask

    // x5 must hold all ones for the console path
    task automatic store_byte(input logic [7:0] val, input logic console);
        issue(enc_addi(5'd6, 5'd0, {4'h0, val}));
        if (console) begin
            issue(enc_store(5'd5, 5'd6, 12'h000));
        end else begin
            issue(enc_store(5'd0, 5'd6, 12'h100));
        end
    endtask

    // x10 checked two cycles after each instruction
    always @(posedge tck) begin
        d1_chk <= cur_chk;
        d2_chk <= d1_chk;
    end

    always @(negedge tck) begin
        if (d2_chk.valid) begin
            check_count++;
            assert (x10_low == d2_chk.x10) else begin
                error_count++;
                $display("Error at %0t: x10_low is %h, expected %h",
                         $time, x10_low, d2_chk.x10);
            end
        end
    end

    // ====================
    // JTAG host
    // ====================
    task automatic jtag_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tms = tms_v;
        tdi = tdi_v;
        @(negedge tck);
        tdo_v = tdo;
        @(posedge tck);
        #0.5;
    endtask

    task automatic tap_reset();
        logic bit_out;
        repeat (5) jtag_step(1'b1, 1'b0, bit_out);
        jtag_step(1'b0, 1'b0, bit_out);
    endtask

    task automatic load_ir(input logic [9:0] code);
        logic       bit_out;
        logic [9:0] captured;
        jtag_step(1'b1, 1'b0, bit_out);
        jtag_step(1'b1, 1'b0, bit_out);
        jtag_step(1'b0, 1'b0, bit_out);
        jtag_step(1'b0, 1'b0, bit_out);
        for (int i = 0; i < 10; i++) begin
            jtag_step(i == 9, code[i], bit_out);
            captured[i] = bit_out;
        end
        jtag_step(1'b1, 1'b0, bit_out);
        jtag_step(1'b0, 1'b0, bit_out);
        check_count++;
        assert (captured[1:0] == 2'b01) else begin
            error_count++;
            $display("Error at %0t: IR capture low bits %b, expected 01", $time, captured[1:0]);
        end
    endtask

    // Starts and ends in Run-Test/Idle
    task automatic dr_scan(input logic [8:0] din, output logic [8:0] dout);
        logic bit_out;
        jtag_step(1'b1, 1'b0, bit_out);
        jtag_step(1'b0, 1'b0, bit_out);
        jtag_step(1'b0, 1'b0, bit_out);
        for (int i = 0; i < 9; i++) begin
            jtag_step(i == 8, din[i], bit_out);
            dout[i] = bit_out;
        end
        jtag_step(1'b1, 1'b0, bit_out);
        jtag_step(1'b0, 1'b0, bit_out);
    endtask

    task automatic check_console_scan();
        logic [8:0] dout;
        logic [8:0] expected;
        if (exp_bytes.size() > 0) begin
            expected = {1'b1, exp_bytes.pop_front()};
        end else begin
            expected = 9'h000;
        end
        dr_scan(9'h000, dout);
        check_count++;
        assert (dout == expected) else begin
            error_count++;
            $display("Error at %0t: USER1 scan returned %h, expected %h", $time, dout, expected);
        end
    endtask

    task automatic drain_console();
        while (exp_bytes.size() > 0) begin
            check_console_scan();
        end
        check_console_scan();
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [31:0] r;
        logic [8:0]  dout;
        logic [4:0]  rd;
        seed        = 32'hb42e;
        error_count = 0;
        check_count = 0;
        tck         = 1'b0;
        reset_n     = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        tms         = 1'b1;
        tdi         = 1'b0;
        cur_chk     = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge tck);
        #0.5;
        reset_n = 1'b1;

        // Bypass scan must not consume the pending byte
        tap_reset();
        issue(enc_addi(5'd5, 5'd0, 12'hFFF));
        store_byte(8'h3C, 1'b1);
        idle(3);
        dr_scan(9'h15A, dout);
        check_count++;
        assert (dout == {8'h5A, 1'b0}) else begin
            error_count++;
            $display("Error at %0t: bypass scan returned %h, expected %h",
                     $time, dout, {8'h5A, 1'b0});
        end
        load_ir(rv_console_pkg::IR_USER1);
        check_console_scan();

        // Empty FIFO scan, then a mix of console and plain stores
        check_console_scan();
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            store_byte(r[7:0], i % 3 != 2);
        end
        idle(3);
        drain_console();

        // Random ADDI with gaps, x0 targets and negative immediates
        for (int i = 0; i < 40; i++) begin
            r  = $random(seed);
            rd = r[4:0];
            if (i % 5 == 0) begin
                rd = 5'd10;
            end else if (i % 7 == 0) begin
                rd = 5'd0;
            end
            if (r[19]) begin
                idle(1);
            end
            issue(enc_addi(rd, r[9:5], r[31:20]));
        end
        idle(3);

        // Dependent chain, one instruction every cycle
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            if (i % 2 == 0) begin
                issue(enc_addi(5'd11, 5'd10, r[11:0]));
            end else begin
                issue(enc_addi(5'd10, 5'd11, r[11:0]));
            end
        end
        idle(3);

        // Overfill the FIFO, only the first 15 bytes survive
        issue(enc_addi(5'd5, 5'd0, 12'hFFF));
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            store_byte(r[7:0], 1'b1);
        end
        idle(3);
        drain_console();
        idle(2);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
